//--- all.f
+incdir+include
rtl/seq_pkg.sv
rtl/insn_tracker.sv
rtl/hazard_scoreboard.sv
rtl/unit_queue_counters.sv
rtl/issue_fsm.sv
rtl/vector_sequencer.sv
test/seq_checker.sv
test/tb_sequencer.sv

//--- include/seq_cfg.svh
////////////////////
// Vector sequencer configuration
// Sizes of the instruction ID pool, the register file and the
// per-unit instruction queues
////////////////////

`ifndef SEQ_CFG_SVH
`define SEQ_CFG_SVH

// Instruction IDs that can be in flight at once
`define SEQ_NR_VINSN 8

// Architectural vector registers
`define SEQ_NR_VREGS 32

// Register read by every masked instruction
`define SEQ_VMASK_REG 0

// Maximum instructions held by each functional unit
`define SEQ_DEPTH_ALU 4
`define SEQ_DEPTH_MUL 4
`define SEQ_DEPTH_LOAD 2
`define SEQ_DEPTH_STORE 2

`endif

//--- rtl/hazard_scoreboard.sv
////////////////////
// Register hazard scoreboard
// Last writer and last reader per vector register, and the
// RAW, WAR and WAW hazard vector of the incoming request
////////////////////

`include "seq_cfg.svh"

module hazard_scoreboard (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  seq_pkg::seq_req_t req_i,
  input  seq_pkg::vmask_t   running_i,
  input  logic              issue_i,
  input  seq_pkg::vid_t     next_id_i,
  output seq_pkg::vmask_t   hazard_o
);

  localparam seq_pkg::vreg_t VMASK = `SEQ_VMASK_REG;

  // Access list entry
  typedef struct packed {
    seq_pkg::vid_t vid;
    logic          valid;
  } vreg_entry_t;

  vreg_entry_t [`SEQ_NR_VREGS-1:0] wr_list_q, wr_list_d;
  vreg_entry_t [`SEQ_NR_VREGS-1:0] rd_list_q, rd_list_d;
  // Lists with finished instructions removed
  vreg_entry_t [`SEQ_NR_VREGS-1:0] wr_live, rd_live;

  ////////////////////
  // Live entries
  ////////////////////

  // Entry stays valid only while its instruction runs
  always_comb begin
    wr_live = wr_list_q;
    rd_live = rd_list_q;
    for (int v = 0; v < `SEQ_NR_VREGS; v++) begin
      wr_live[v].valid = wr_list_q[v].valid & running_i[wr_list_q[v].vid];
      rd_live[v].valid = rd_list_q[v].valid & running_i[rd_list_q[v].vid];
    end
  end

  ////////////////////
  // Hazard vector
  ////////////////////

  always_comb begin
    hazard_o = '0;
    // RAW on the sources
    if (req_i.use_vs1 && wr_live[req_i.vs1].valid) begin
      hazard_o[wr_live[req_i.vs1].vid] = 1'b1;
    end
    if (req_i.use_vs2 && wr_live[req_i.vs2].valid) begin
      hazard_o[wr_live[req_i.vs2].vid] = 1'b1;
    end
    // RAW on the mask register
    if (!req_i.vm && wr_live[VMASK].valid) begin
      hazard_o[wr_live[VMASK].vid] = 1'b1;
    end
    if (req_i.use_vd) begin
      // WAW
      if (wr_live[req_i.vd].valid) begin
        hazard_o[wr_live[req_i.vd].vid] = 1'b1;
      end
      // WAR
      if (rd_live[req_i.vd].valid) begin
        hazard_o[rd_live[req_i.vd].vid] = 1'b1;
      end
    end
  end

  // Newest access replaces the older one
  always_comb begin
    wr_list_d = wr_live;
    rd_list_d = rd_live;
    if (issue_i) begin
      if (req_i.use_vd) begin
        wr_list_d[req_i.vd] = '{vid: next_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        rd_list_d[req_i.vs1] = '{vid: next_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        rd_list_d[req_i.vs2] = '{vid: next_id_i, valid: 1'b1};
      end
      if (!req_i.vm) begin
        rd_list_d[VMASK] = '{vid: next_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_list_q <= '0;
      rd_list_q <= '0;
    end else begin
      wr_list_q <= wr_list_d;
      rd_list_q <= rd_list_d;
    end
  end

endmodule

//--- rtl/insn_tracker.sv
////////////////////
// Running instruction tracker
// One running mask per functional unit, lowest free ID
// allocation, and the pool idle and full flags
////////////////////

`include "seq_cfg.svh"

module insn_tracker (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_i,
  input  seq_pkg::unit_req_t  issue_req_i,
  input  seq_pkg::unit_done_t unit_done_i,
  output seq_pkg::vmask_t     running_o,
  output seq_pkg::vid_t       next_id_o,
  output logic                full_o,
  output logic                idle_o
);

  // Row per unit, column per instruction ID
  logic [3:0][`SEQ_NR_VINSN-1:0] rows_q, rows_d;
  logic [3:0][`SEQ_NR_VINSN-1:0] done_rows;

  // Done fields line up with the unit rows
  assign done_rows = unit_done_i;

  always_comb begin
    // Completions clear their bits
    rows_d = rows_q & ~done_rows;
    // New instruction enters its unit row
    if (issue_i) begin
      rows_d[issue_req_i.unit][issue_req_i.id] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rows_q <= '0;
    end else begin
      rows_q <= rows_d;
    end
  end

  // Instruction is running if any unit holds it
  assign running_o = rows_q[0] | rows_q[1] | rows_q[2] | rows_q[3];
  assign full_o    = &running_o;
  assign idle_o    = ~|running_o;

  // Priority search from the top so the lowest free ID wins
  always_comb begin
    next_id_o = '0;
    for (int i = `SEQ_NR_VINSN - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = seq_pkg::vid_t'(i);
      end
    end
  end

  // A unit only completes instructions that it is running
  a_done_running: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (done_rows & ~rows_q) == '0
  );

endmodule

//--- rtl/issue_fsm.sv
////////////////////
// Issue state machine
// Dispatcher handshake, registered unit request and the
// address generation response for memory operations
////////////////////

module issue_fsm (
  input  logic               clk_i,
  input  logic               rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t  req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  // Tracker, scoreboard and counters
  input  seq_pkg::vmask_t    running_i,
  input  seq_pkg::vid_t      next_id_i,
  input  logic               full_i,
  input  seq_pkg::vmask_t    hazard_i,
  input  logic [3:0]         unit_ready_i,
  // Functional units
  input  logic               unit_req_ready_i,
  output seq_pkg::unit_req_t unit_req_o,
  output logic               unit_req_valid_o,
  // Issue strobe to the bookkeeping blocks
  output logic               issue_o,
  output seq_pkg::unit_req_t issue_req_o,
  // Address generation
  input  logic               addrgen_ack_i,
  input  logic               addrgen_error_i,
  output seq_pkg::seq_resp_t resp_o,
  output logic               resp_valid_o
);

  seq_pkg::seq_state_e state_q, state_d;
  seq_pkg::unit_e      unit;
  logic                is_mem;
  logic                held;

  assign unit   = seq_pkg::unit_of(req_i.op);
  assign is_mem = (unit == seq_pkg::UNIT_LOAD) || (unit == seq_pkg::UNIT_STORE);
  // Previous request still waits for its unit
  assign held   = unit_req_valid_o && !unit_req_ready_i;

  assign issue_o = (state_q == seq_pkg::IDLE) && req_valid_i && !held &&
                   !full_i && unit_ready_i[unit];

  // Unit request built from the dispatcher fields
  assign issue_req_o = '{
    id:     next_id_i,
    op:     req_i.op,
    unit:   unit,
    vd:     req_i.vd,
    vs1:    req_i.vs1,
    vs2:    req_i.vs2,
    vm:     req_i.vm,
    hazard: hazard_i
  };

  ////////////////////
  // Handshake and response
  ////////////////////

  always_comb begin
    state_d      = state_q;
    req_ready_o  = 1'b0;
    resp_o       = '0;
    resp_valid_o = 1'b0;
    unique case (state_q)
      seq_pkg::IDLE: begin
        if (held) begin
          req_ready_o = 1'b0;
        end else if (req_valid_i) begin
          // Memory ops finish their handshake on the ack
          req_ready_o = issue_o && !is_mem;
          if (issue_o && is_mem) begin
            state_d = seq_pkg::WAIT;
          end
        end else begin
          req_ready_o = 1'b1;
        end
      end
      seq_pkg::WAIT: begin
        if (addrgen_ack_i) begin
          req_ready_o  = 1'b1;
          resp_valid_o = 1'b1;
          resp_o.error = addrgen_error_i;
          state_d      = seq_pkg::IDLE;
        end
      end
      default: state_d = seq_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q          <= seq_pkg::IDLE;
      unit_req_valid_o <= 1'b0;
    end else begin
      state_q          <= state_d;
      unit_req_valid_o <= issue_o || held;
    end
  end

  // Payload loads only on issue, so a held request stays put
  always_ff @(posedge clk_i) begin
    if (issue_o) begin
      unit_req_o <= issue_req_o;
    end
  end

  a_ack_in_wait: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    addrgen_ack_i |-> (state_q == seq_pkg::WAIT)
  );

  // Hazards point at running instructions and the new ID is free
  a_issue_consistent: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    issue_o |-> (((hazard_i & ~running_i) == '0) && !running_i[next_id_i])
  );

endmodule

//--- rtl/seq_pkg.sv
////////////////////
// Vector sequencer types
// Opcodes, unit encoding, request and response structs
// and the opcode to unit mapping
////////////////////

`include "seq_cfg.svh"

package seq_pkg;

  // Basic index types
  typedef logic [$clog2(`SEQ_NR_VINSN)-1:0] vid_t;
  typedef logic [$clog2(`SEQ_NR_VREGS)-1:0] vreg_t;
  // One bit per instruction ID
  typedef logic [`SEQ_NR_VINSN-1:0] vmask_t;

  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VMUL,
    VMACC,
    VLE,
    VSE
  } op_e;

  // Encoding doubles as the row index of the per-unit matrices
  typedef enum logic [1:0] {
    UNIT_ALU   = 2'd0,
    UNIT_MUL   = 2'd1,
    UNIT_LOAD  = 2'd2,
    UNIT_STORE = 2'd3
  } unit_e;

  typedef enum logic {
    IDLE,
    WAIT
  } seq_state_e;

  // Request from the dispatcher
  typedef struct packed {
    op_e   op;
    vreg_t vd;
    vreg_t vs1;
    vreg_t vs2;
    logic  use_vd;
    logic  use_vs1;
    logic  use_vs2;
    // High for unmasked instructions
    logic  vm;
  } seq_req_t;

  // Request issued to a functional unit
  typedef struct packed {
    vid_t   id;
    op_e    op;
    unit_e  unit;
    vreg_t  vd;
    vreg_t  vs1;
    vreg_t  vs2;
    logic   vm;
    vmask_t hazard;
  } unit_req_t;

  typedef struct packed {
    logic error;
  } seq_resp_t;

  // Field order puts the ALU in the low byte
  // so that the struct maps onto rows indexed by unit_e
  typedef struct packed {
    vmask_t store;
    vmask_t load;
    vmask_t mul;
    vmask_t alu;
  } unit_done_t;

  // Functional unit that executes an opcode
  function automatic unit_e unit_of(op_e op);
    unit_e unit;
    unique case (op)
      VMUL, VMACC: unit = UNIT_MUL;
      VLE:         unit = UNIT_LOAD;
      VSE:         unit = UNIT_STORE;
      default:     unit = UNIT_ALU;
    endcase
    return unit;
  endfunction

endpackage

//--- rtl/unit_queue_counters.sv
////////////////////
// Unit queue counters
// Occupancy per functional unit and the per-unit ready flags
////////////////////

`include "seq_cfg.svh"

module unit_queue_counters (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                issue_i,
  input  seq_pkg::unit_e      issue_unit_i,
  input  seq_pkg::unit_done_t unit_done_i,
  output logic [3:0]          unit_ready_o
);

  // Indexed by unit encoding
  localparam int unsigned DEPTH [4] = '{
    `SEQ_DEPTH_ALU, `SEQ_DEPTH_MUL, `SEQ_DEPTH_LOAD, `SEQ_DEPTH_STORE
  };

  function automatic int unsigned max_depth();
    int unsigned m;
    m = 0;
    for (int u = 0; u < 4; u++) begin
      if (DEPTH[u] > m) begin
        m = DEPTH[u];
      end
    end
    return m;
  endfunction

  localparam int unsigned CNT_W = $clog2(max_depth() + 1);

  logic [3:0][`SEQ_NR_VINSN-1:0] done_rows;

  assign done_rows = unit_done_i;

  for (genvar u = 0; u < 4; u++) begin : gen_cnt
    logic [CNT_W-1:0] cnt_q;
    logic             up;
    logic             down;

    assign up   = issue_i && (issue_unit_i == u);
    // At most one completion per unit and cycle
    assign down = |done_rows[u];

    // Issue and completion together leave the count alone
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (up && !down) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (down && !up) begin
        cnt_q <= cnt_q - 1'b1;
      end
    end

    assign unit_ready_o[u] = cnt_q < DEPTH[u];

    a_no_underflow: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (down && !up) |-> (cnt_q != '0)
    );
    a_no_overflow: assert property (
      @(posedge clk_i) disable iff (!rst_ni)
      (up && !down) |-> (cnt_q < DEPTH[u])
    );
  end

endmodule

//--- rtl/vector_sequencer.sv
////////////////////
// Vector instruction sequencer
// In-order issue to ALU, multiplier, load and store units
// with hazard tracking and per-unit queue limits
////////////////////

module vector_sequencer (
  input  logic                clk_i,
  input  logic                rst_ni,
  // Dispatcher
  input  seq_pkg::seq_req_t   req_i,
  input  logic                req_valid_i,
  output logic                req_ready_o,
  output seq_pkg::seq_resp_t  resp_o,
  output logic                resp_valid_o,
  output logic                idle_o,
  // Functional units
  output seq_pkg::unit_req_t  unit_req_o,
  output logic                unit_req_valid_o,
  input  logic                unit_req_ready_i,
  input  seq_pkg::unit_done_t unit_done_i,
  // Address generation
  input  logic                addrgen_ack_i,
  input  logic                addrgen_error_i
);

  seq_pkg::vmask_t    running;
  seq_pkg::vid_t      next_id;
  logic               full;
  seq_pkg::vmask_t    hazard;
  logic [3:0]         unit_ready;
  logic               issue;
  seq_pkg::unit_req_t issue_req;

  // Running set and ID allocation
  insn_tracker i_tracker (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .issue_i     (issue),
    .issue_req_i (issue_req),
    .unit_done_i (unit_done_i),
    .running_o   (running),
    .next_id_o   (next_id),
    .full_o      (full),
    .idle_o      (idle_o)
  );

  // Register access lists
  hazard_scoreboard i_scoreboard (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .req_i     (req_i),
    .running_i (running),
    .issue_i   (issue),
    .next_id_i (next_id),
    .hazard_o  (hazard)
  );

  // Queue occupancy per unit
  unit_queue_counters i_counters (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (issue),
    .issue_unit_i (seq_pkg::unit_of(req_i.op)),
    .unit_done_i  (unit_done_i),
    .unit_ready_o (unit_ready)
  );

  issue_fsm i_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req_i),
    .req_valid_i      (req_valid_i),
    .req_ready_o      (req_ready_o),
    .running_i        (running),
    .next_id_i        (next_id),
    .full_i           (full),
    .hazard_i         (hazard),
    .unit_ready_i     (unit_ready),
    .unit_req_ready_i (unit_req_ready_i),
    .unit_req_o       (unit_req_o),
    .unit_req_valid_o (unit_req_valid_o),
    .issue_o          (issue),
    .issue_req_o      (issue_req),
    .addrgen_ack_i    (addrgen_ack_i),
    .addrgen_error_i  (addrgen_error_i),
    .resp_o           (resp_o),
    .resp_valid_o     (resp_valid_o)
  );

endmodule

//--- test/seq_cases.txt
# R op vd vs1 vs2 use_vd use_vs1 use_vs2 vm id unit hazard(hex) resp error stall
# op 0 vadd 1 vsub 2 vand 3 vmul 4 vmacc 5 vle 6 vse; unit 0 alu 1 mul 2 load 3 store
# D unit id; A error; P cycles of unit back-pressure
R 0  1  2  3 1 1 1 1  0 0 00 0 0 0
R 3  4  5  6 1 1 1 1  1 1 00 0 0 0
R 1  7  1  8 1 1 1 1  2 0 01 0 0 0
R 2  5  4  9 1 1 1 1  3 0 02 0 0 0
R 4  7 10 11 1 1 1 0  4 1 04 0 0 0
R 0  0 12 13 1 1 1 1  5 0 10 0 0 0
D 0 0
D 1 1
R 1  2  1  7 1 1 1 0  0 0 30 0 0 0
D 0 2
D 0 3
D 1 4
D 0 5
D 0 0
R 5 20  0  0 1 0 0 1  0 2 00 1 0 0
A 0
R 5 21  0  0 1 0 0 1  1 2 00 1 0 0
A 0
R 5 22  0  0 1 0 0 1  0 2 00 1 0 3
D 2 0
A 0
R 6  0 21  0 0 1 0 1  2 3 02 1 1 0
A 1
D 2 1
D 2 0
D 3 2
P 6
R 0  3  4  5 1 1 1 1  0 0 00 0 0 0
R 3  6  3  7 1 1 1 1  1 1 01 0 0 0
D 0 0
D 1 1

//--- test/seq_checker.sv
////////////////////
// Vector sequencer checker
// Watches the DUT ports, compares unit requests and responses
// with the expected values and counts errors
////////////////////

module seq_checker (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  seq_pkg::unit_req_t unit_req_i,
  input  logic               unit_req_valid_i,
  input  logic               unit_req_ready_i,
  input  logic               req_ready_i,
  input  seq_pkg::seq_resp_t resp_i,
  input  logic               resp_valid_i,
  input  logic               addrgen_ack_i,
  output int                 error_cnt_o,
  output int                 check_cnt_o,
  output int                 issued_cnt_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Expected traffic in issue order
  seq_pkg::unit_req_t issue_q[$];
  logic               resp_q[$];

  int                 errors = 0;
  int                 checks = 0;
  int                 issued = 0;
  logic               held_q;
  seq_pkg::unit_req_t held_req_q;
  seq_pkg::unit_req_t exp_req;
  logic               exp_err;

  assign error_cnt_o  = errors;
  assign check_cnt_o  = checks;
  assign issued_cnt_o = issued;

  task automatic report_error(string msg);
    errors++;
    $display("Error at %0t: %s", $time, msg);
  endtask

  // Failures that are not a wrong value
  task automatic count_failure(string msg);
    errors++;
    $display("%s", msg);
  endtask

  task automatic expect_issue(seq_pkg::unit_req_t exp);
    issue_q.push_back(exp);
  endtask

  task automatic expect_resp(logic err);
    resp_q.push_back(err);
  endtask

  task automatic check_flag(logic actual, logic expected, string what);
    checks++;
    if (actual !== expected) begin
      report_error($sformatf("%s, got %b expected %b", what, actual, expected));
    end
  endtask

  // Every expected request and response must have shown up
  task automatic final_check();
    if (issue_q.size() != 0) begin
      count_failure($sformatf("%0d expected unit requests never reached a unit",
                              issue_q.size()));
    end
    if (resp_q.size() != 0) begin
      count_failure($sformatf("%0d expected responses never arrived", resp_q.size()));
    end
  endtask

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      held_q <= 1'b0;
    end else begin
      // Unit request handshake
      if (unit_req_valid_i && unit_req_ready_i) begin
        issued++;
        if (issue_q.size() == 0) begin
          report_error("unit request accepted with no issue expected");
        end else begin
          exp_req = issue_q.pop_front();
          checks++;
          if (unit_req_i !== exp_req) begin
            report_error($sformatf(
              "unit request id %0d op %0d unit %0d hazard %h, expected %0d %0d %0d %h",
              unit_req_i.id, unit_req_i.op, unit_req_i.unit, unit_req_i.hazard,
              exp_req.id, exp_req.op, exp_req.unit, exp_req.hazard));
          end
        end
      end
      // Held request stays frozen
      if (held_q) begin
        checks++;
        if (unit_req_i !== held_req_q) begin
          report_error("unit_req_o changed while the unit held it back");
        end
      end
      if (unit_req_valid_i && !unit_req_ready_i) begin
        check_flag(req_ready_i, 1'b0, "req_ready_o while the unit request is held");
      end
      held_q     <= unit_req_valid_i && !unit_req_ready_i;
      held_req_q <= unit_req_i;
      // One response per memory op, only in the ack cycle
      if (resp_valid_i) begin
        check_flag(addrgen_ack_i, 1'b1, "resp_valid_o outside the acknowledgment cycle");
        if (resp_q.size() == 0) begin
          report_error("response with no memory operation waiting");
        end else begin
          exp_err = resp_q.pop_front();
          check_flag(resp_i.error, exp_err, "response error flag");
        end
      end
    end
  end

endmodule

//--- test/tb_sequencer.sv
////////////////////
// Vector sequencer testbench
// Replays the events of the cases file against the DUT
// and hands the expected traffic to the checker
////////////////////

`include "seq_cfg.svh"

module tb_sequencer;
  timeunit 1ns;
  timeprecision 100ps;

  logic                clk_i;
  logic                rst_ni;
  seq_pkg::seq_req_t   req;
  logic                req_valid;
  logic                req_ready;
  seq_pkg::seq_resp_t  resp;
  logic                resp_valid;
  logic                idle;
  seq_pkg::unit_req_t  unit_req;
  logic                unit_req_valid;
  logic                unit_req_ready;
  seq_pkg::unit_done_t unit_done;
  logic                ack;
  logic                ack_err;
  int                  error_cnt;
  int                  check_cnt;
  int                  issued;

  string lines[$];
  string tag;
  int    seed = 32'h73ab_6b6e;
  int    rc;
  int    pushed = 0;
  int    cycle = 0;
  int    limit = 0;
  int    pause_cycles;
  logic  pending;

  always #4 clk_i = ~clk_i;

  vector_sequencer DUT (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .req_i            (req),
    .req_valid_i      (req_valid),
    .req_ready_o      (req_ready),
    .resp_o           (resp),
    .resp_valid_o     (resp_valid),
    .idle_o           (idle),
    .unit_req_o       (unit_req),
    .unit_req_valid_o (unit_req_valid),
    .unit_req_ready_i (unit_req_ready),
    .unit_done_i      (unit_done),
    .addrgen_ack_i    (ack),
    .addrgen_error_i  (ack_err)
  );

  seq_checker u_checker (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .unit_req_i       (unit_req),
    .unit_req_valid_i (unit_req_valid),
    .unit_req_ready_i (unit_req_ready),
    .req_ready_i      (req_ready),
    .resp_i           (resp),
    .resp_valid_i     (resp_valid),
    .addrgen_ack_i    (ack),
    .error_cnt_o      (error_cnt),
    .check_cnt_o      (check_cnt),
    .issued_cnt_o     (issued)
  );

  // Run limit scales with the number of events
  always @(posedge clk_i) begin
    cycle <= cycle + 1;
    if (limit != 0 && cycle >= limit) begin
      $display("Timeout: the run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic load_cases();
    int    fd;
    string line;
    fd = $fopen("test/seq_cases.txt", "r");
    if (fd == 0) begin
      u_checker.count_failure("Could not open the cases file test/seq_cases.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        // Skip comments and empty lines
        if (line.len() > 1 && line[0] != "#") begin
          lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  // Hold the request until the handshake edge
  task automatic wait_accept();
    @(posedge clk_i);
    while (!req_ready) begin
      @(posedge clk_i);
    end
    @(negedge clk_i);
    req_valid = 1'b0;
    pending   = 1'b0;
  endtask

  task automatic run_request(string line);
    int                 op, vd, vs1, vs2, uvd, uvs1, uvs2, vm;
    int                 id, unit, haz, resp_exp, err, stall;
    seq_pkg::unit_req_t exp;
    rc = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %h %d %d %d", tag, op, vd, vs1,
                 vs2, uvd, uvs1, uvs2, vm, id, unit, haz, resp_exp, err, stall);
    if (pending) begin
      wait_accept();
    end
    // Random idle gap before the next request
    repeat ($unsigned($random(seed)) % 3) @(negedge clk_i);
    req.op      = seq_pkg::op_e'(op);
    req.vd      = seq_pkg::vreg_t'(vd);
    req.vs1     = seq_pkg::vreg_t'(vs1);
    req.vs2     = seq_pkg::vreg_t'(vs2);
    req.use_vd  = uvd[0];
    req.use_vs1 = uvs1[0];
    req.use_vs2 = uvs2[0];
    req.vm      = vm[0];
    exp.id      = seq_pkg::vid_t'(id);
    exp.op      = req.op;
    exp.unit    = seq_pkg::unit_e'(unit);
    exp.vd      = req.vd;
    exp.vs1     = req.vs1;
    exp.vs2     = req.vs2;
    exp.vm      = req.vm;
    exp.hazard  = seq_pkg::vmask_t'(haz);
    u_checker.expect_issue(exp);
    if (resp_exp != 0) begin
      u_checker.expect_resp(err[0]);
    end
    req_valid = 1'b1;
    pending   = 1'b1;
    pushed++;
    if (stall > 0) begin
      // Full unit queue must hold the request back
      repeat (stall) begin
        @(posedge clk_i);
        u_checker.check_flag(req_ready, 1'b0, "req_ready_o with the unit queue full");
        u_checker.check_flag(unit_req_valid, 1'b0, "issue with the unit queue full");
      end
      @(negedge clk_i);
    end else if (resp_exp == 0) begin
      wait_accept();
    end
  endtask

  task automatic run_done(string line);
    int                          unit, id;
    logic [4*`SEQ_NR_VINSN-1:0] bits;
    rc = $sscanf(line, "%s %d %d", tag, unit, id);
    bits = '0;
    bits[unit*`SEQ_NR_VINSN+id] = 1'b1;
    unit_done = bits;
    @(negedge clk_i);
    unit_done = '0;
  endtask

  task automatic run_ack(string line);
    int err;
    rc = $sscanf(line, "%s %d", tag, err);
    // Memory op must have reached its unit first
    while (issued != pushed) begin
      @(negedge clk_i);
    end
    ack     = 1'b1;
    ack_err = err[0];
    @(posedge clk_i);
    u_checker.check_flag(req_ready, 1'b1, "req_ready_o in the acknowledgment cycle");
    // Memory op still counts as running
    u_checker.check_flag(idle, 1'b0, "idle_o with an instruction running");
    @(negedge clk_i);
    ack       = 1'b0;
    ack_err   = 1'b0;
    req_valid = 1'b0;
    pending   = 1'b0;
  endtask

  // Back-pressure runs alongside the following events
  task run_pause(string line);
    rc = $sscanf(line, "%s %d", tag, pause_cycles);
    fork
      begin
        unit_req_ready = 1'b0;
        repeat (pause_cycles) @(negedge clk_i);
        unit_req_ready = 1'b1;
      end
    join_none
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    req            = '0;
    req_valid      = 1'b0;
    unit_req_ready = 1'b1;
    unit_done      = '0;
    ack            = 1'b0;
    ack_err        = 1'b0;
    pending        = 1'b0;
    load_cases();
    limit = 40 * lines.size();
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(posedge clk_i);
    u_checker.check_flag(idle, 1'b1, "idle_o after reset");
    @(negedge clk_i);
    foreach (lines[i]) begin
      rc = $sscanf(lines[i], "%s", tag);
      if (tag == "R") begin
        run_request(lines[i]);
      end else if (tag == "D") begin
        run_done(lines[i]);
      end else if (tag == "A") begin
        run_ack(lines[i]);
      end else if (tag == "P") begin
        run_pause(lines[i]);
      end else begin
        u_checker.count_failure($sformatf("Unknown event %s in the cases file", tag));
      end
    end
    if (pending) begin
      wait_accept();
    end
    repeat (2) @(posedge clk_i);
    u_checker.check_flag(idle, 1'b1, "idle_o after all instructions completed");
    u_checker.final_check();
    @(negedge clk_i);
    $display("Checks: %0d, errors: %0d", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
